// File: hdl/botPkg.sv
`default_nettype none

package botPkg;

	// ----------------------------------------
	// Shared widths and reset values
	// ----------------------------------------

	// Encoder counts and pulse widths in clock cycles
	localparam int COUNT_W = 32;
	// Speed percent, 0 to 200
	localparam int PCT_W = 8;

	// Start at half range so the count never wraps in normal driving
	localparam logic [COUNT_W-1:0] ENC_RESET_COUNT = 32'h8000_0000;
	// 100 percent is the 1.5 ms center, motor at rest
	localparam logic [PCT_W-1:0] PCT_CENTER = 8'd100;

	// ----------------------------------------
	// Command frame from the host
	// ----------------------------------------

	// Byte 0 of the frame
	typedef struct packed {
		logic [6:0] reserved;
		// 1 = FPGA pulse generators, 0 = RC receiver passthrough
		logic motorSourceSelect;
	} cmdFlags_t;

	// Declared MSB first, so byte 0 sits in bits 7:0
	typedef struct packed {
		logic [PCT_W-1:0] spare;
		logic [PCT_W-1:0] leftPercent;
		logic [PCT_W-1:0] rightPercent;
		cmdFlags_t flags;
	} cmdFrame_t;

	// Both wheel encoder counts
	typedef struct packed {
		logic [COUNT_W-1:0] left;
		logic [COUNT_W-1:0] right;
	} encCounts_t;

	// DIP switch code for the LED bank
	typedef enum logic [3:0] {
		LED_LEFT_COUNT  = 4'd0,
		LED_RIGHT_COUNT = 4'd1,
		LED_HEARTBEAT   = 4'd7,
		LED_CMD_B0      = 4'd8,
		LED_CMD_B1      = 4'd9,
		LED_CMD_B2      = 4'd10,
		LED_CMD_B3      = 4'd11,
		LED_RPULSE_B0   = 4'd12,
		LED_RPULSE_B1   = 4'd13,
		LED_RPULSE_B2   = 4'd14,
		LED_RPULSE_B3   = 4'd15
	} ledMode_t;

endpackage

`default_nettype wire

// File: hdl/spiCommandSlave.sv
`timescale 1ns/100ps
`default_nettype none

module spiCommandSlave (
	input  wire              OSC_FPGA,
	input  wire              rstN_i,
	input  wire              spiSck_i,
	input  wire              spiMosi_i,
	input  wire              spiSsN_i,
	output botPkg::cmdFrame_t cmd_o,
	output logic             cmdValid_o
);

	import botPkg::*;

	// ----------------------------------------
	// Pin synchronizers
	// ----------------------------------------

	// Bit 2 is the previous synced value, for edge detect
	logic [2:0] sckSync;
	logic [2:0] ssSync;
	// MOSI gets the same two-flop delay as SCK
	logic [1:0] mosiSync;

	logic sckRise;
	logic ssRise;

	// Shift register and bit counter
	logic [31:0] shiftReg;
	logic [5:0] bitCount;

	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			sckSync <= 3'b000;
			// Chip select idles high
			ssSync <= 3'b111;
			mosiSync <= 2'b00;
		end
		else
		begin
			sckSync <= {sckSync[1:0], spiSck_i};
			ssSync <= {ssSync[1:0], spiSsN_i};
			mosiSync <= {mosiSync[0], spiMosi_i};
		end
	end

	// Mode 0, data sampled on SCK rising
	assign sckRise = sckSync[1] & ~sckSync[2];
	// End of frame
	assign ssRise = ssSync[1] & ~ssSync[2];

	// ----------------------------------------
	// Frame capture
	// ----------------------------------------

	// MSB first, so the first wire byte ends up in bits 31:24
	always_ff @(posedge OSC_FPGA)
	begin
		if (!ssSync[1] && sckRise)
			shiftReg <= {shiftReg[30:0], mosiSync[1]};
	end

	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			bitCount <= '0;
			cmdValid_o <= 1'b0;
			// Motors at rest, RC passthrough
			cmd_o <= '{spare: '0, leftPercent: PCT_CENTER, rightPercent: PCT_CENTER,
				flags: '0};
		end
		else
		begin
			cmdValid_o <= 1'b0;
			if (ssRise)
			begin
				bitCount <= '0;
				// Only a full 32 bit frame is accepted
				if (bitCount == 6'd32)
				begin
					// Swap bytes, first wire byte becomes byte 0
					cmd_o <= cmdFrame_t'({shiftReg[7:0], shiftReg[15:8],
						shiftReg[23:16], shiftReg[31:24]});
					cmdValid_o <= 1'b1;
				end
			end
			else if (ssSync[1])
				bitCount <= '0;
			// Saturate so long frames never alias to 32
			else if (sckRise && bitCount != '1)
				bitCount <= bitCount + 6'd1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/quadratureCounter.sv
`timescale 1ns/100ps
`default_nettype none

module quadratureCounter (
	input  wire                        OSC_FPGA,
	input  wire                        rstN_i,
	input  wire                        encA_i,
	input  wire                        encB_i,
	output logic [botPkg::COUNT_W-1:0] count_o
);

	import botPkg::*;

	// Two-flop synchronizer per channel, {A,B} pairs
	logic [1:0] abMeta;
	logic [1:0] abSync;
	// State from the cycle before
	logic [1:0] abPrev;

	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			abMeta <= 2'b00;
			abSync <= 2'b00;
			abPrev <= 2'b00;
		end
		else
		begin
			abMeta <= {encA_i, encB_i};
			abSync <= abMeta;
			abPrev <= abSync;
		end
	end

	// ----------------------------------------
	// Count on every valid step
	// ----------------------------------------

	// Forward: 00 -> 10 -> 11 -> 01 -> 00
	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
			count_o <= ENC_RESET_COUNT;
		else
		begin
			case ({abPrev, abSync})
				4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00:
					count_o <= count_o + 1'b1;
				// Reverse sequence
				4'b10_00, 4'b11_10, 4'b01_11, 4'b00_01:
					count_o <= count_o - 1'b1;
				// No change, or both bits flipped
				default:
					count_o <= count_o;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/rcPulseGenerator.sv
`timescale 1ns/100ps
`default_nettype none

module rcPulseGenerator #(
	// Period in clock cycles
	parameter int PulsePeriod = 1100000
) (
	input  wire                        OSC_FPGA,
	input  wire                        rstN_i,
	input  wire [botPkg::COUNT_W-1:0]  pulseWidth_i,
	output logic                       pulse_o
);

	import botPkg::*;

	logic [COUNT_W-1:0] periodCount;
	// Width held for the whole period
	logic [COUNT_W-1:0] latchedWidth;
	// Live width at count 0, latched width after
	logic [COUNT_W-1:0] activeWidth;

	assign activeWidth = (periodCount == '0) ? pulseWidth_i : latchedWidth;

	// ----------------------------------------
	// Period counter
	// ----------------------------------------

	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
			periodCount <= '0;
		else if (periodCount == COUNT_W'(PulsePeriod - 1))
			periodCount <= '0;
		else
			periodCount <= periodCount + 1'b1;
	end

	// Width only changes at the start of a period
	always_ff @(posedge OSC_FPGA)
	begin
		if (periodCount == '0)
			latchedWidth <= pulseWidth_i;
	end

	// ----------------------------------------
	// Output
	// ----------------------------------------

	// High for counts 0 to width-1, one cycle late
	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
			pulse_o <= 1'b0;
		else
			pulse_o <= (periodCount < activeWidth);
	end

endmodule

`default_nettype wire

// File: hdl/motorDrive.sv
`timescale 1ns/100ps
`default_nettype none

module motorDrive #(
	parameter int PulsePeriod = 1100000,
	// 1.0 ms pulse, full throw one way
	parameter int PulseLowLimit = 50000,
	// Cycles per percent
	parameter int PulseRangeStep = 250
) (
	input  wire                        OSC_FPGA,
	input  wire                        rstN_i,
	input  wire botPkg::cmdFrame_t     cmd_i,
	input  wire                        cmdValid_i,
	input  wire                        rcLeft_i,
	input  wire                        rcRight_i,
	output logic                       motorLeft_o,
	output logic                       motorRight_o,
	output logic [botPkg::COUNT_W-1:0] rightPulseWidth_o
);

	import botPkg::*;

	// Percent to on-time in clock cycles
	function automatic logic [COUNT_W-1:0] pctToWidth(input logic [PCT_W-1:0] pct);
		return COUNT_W'(PulseLowLimit) + COUNT_W'(pct) * COUNT_W'(PulseRangeStep);
	endfunction

	// Setpoints from the last command
	logic [PCT_W-1:0] leftPct;
	logic [PCT_W-1:0] rightPct;
	logic sourceSelect;

	logic [COUNT_W-1:0] leftWidth;
	logic [COUNT_W-1:0] rightWidth;

	logic genLeft;
	logic genRight;

	// ----------------------------------------
	// Setpoints and widths
	// ----------------------------------------

	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			leftPct <= PCT_CENTER;
			rightPct <= PCT_CENTER;
			sourceSelect <= 1'b0;
			leftWidth <= pctToWidth(PCT_CENTER);
			rightWidth <= pctToWidth(PCT_CENTER);
		end
		else
		begin
			if (cmdValid_i)
			begin
				leftPct <= cmd_i.leftPercent;
				rightPct <= cmd_i.rightPercent;
				sourceSelect <= cmd_i.flags.motorSourceSelect;
			end
			// One cycle behind the setpoints
			leftWidth <= pctToWidth(leftPct);
			rightWidth <= pctToWidth(rightPct);
		end
	end

	// ----------------------------------------
	// Pulse generators and source mux
	// ----------------------------------------

	rcPulseGenerator #(.PulsePeriod(PulsePeriod)) leftGen_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN_i),
		.pulseWidth_i(leftWidth),
		.pulse_o(genLeft)
	);

	rcPulseGenerator #(.PulsePeriod(PulsePeriod)) rightGen_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN_i),
		.pulseWidth_i(rightWidth),
		.pulse_o(genRight)
	);

	// Passthrough stays combinational
	assign motorLeft_o = sourceSelect ? genLeft : rcLeft_i;
	assign motorRight_o = sourceSelect ? genRight : rcRight_i;

	// For the LED debug modes
	assign rightPulseWidth_o = rightWidth;

endmodule

`default_nettype wire

// File: hdl/ledDebugDisplay.sv
`timescale 1ns/100ps
`default_nettype none

module ledDebugDisplay #(
	// 500 ms at 50 MHz
	parameter int HeartbeatCycles = 25000000
) (
	input  wire                        OSC_FPGA,
	input  wire                        rstN_i,
	input  wire [3:0]                  dipSw_i,
	input  wire botPkg::encCounts_t    encCounts_i,
	input  wire botPkg::cmdFrame_t     cmd_i,
	input  wire [botPkg::COUNT_W-1:0]  rightPulseWidth_i,
	output logic [7:0]                 leds_o
);

	import botPkg::*;

	ledMode_t mode;
	// Flat view of the command for byte select
	logic [31:0] cmdBits;
	// Byte offset from the low two switch bits
	logic [4:0] byteSel;
	logic [COUNT_W-1:0] hbCount;

	assign mode = ledMode_t'(dipSw_i);
	assign cmdBits = cmd_i;
	assign byteSel = {dipSw_i[1:0], 3'b000};

	// ----------------------------------------
	// Heartbeat down-counter
	// ----------------------------------------

	// Runs only while the heartbeat mode is selected
	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
			hbCount <= COUNT_W'(HeartbeatCycles);
		else if (mode == LED_HEARTBEAT)
		begin
			if (hbCount == '0)
				hbCount <= COUNT_W'(HeartbeatCycles);
			else
				hbCount <= hbCount - 1'b1;
		end
	end

	// ----------------------------------------
	// LED register
	// ----------------------------------------

	always_ff @(posedge OSC_FPGA or negedge rstN_i)
	begin
		if (!rstN_i)
			leds_o <= 8'h00;
		else
		begin
			case (mode)
				LED_LEFT_COUNT:
					leds_o <= encCounts_i.left[7:0];
				LED_RIGHT_COUNT:
					leds_o <= encCounts_i.right[7:0];
				// Blink the whole bank
				LED_HEARTBEAT:
					if (hbCount == '0)
						leds_o <= ~leds_o;
				LED_CMD_B0, LED_CMD_B1, LED_CMD_B2, LED_CMD_B3:
					leds_o <= cmdBits[byteSel +: 8];
				LED_RPULSE_B0, LED_RPULSE_B1, LED_RPULSE_B2, LED_RPULSE_B3:
					leds_o <= rightPulseWidth_i[byteSel +: 8];
				// Unused codes hold
				default:
					leds_o <= leds_o;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/botTop.sv
`timescale 1ns/100ps
`default_nettype none

module botTop #(
	// 22 ms period at 50 MHz
	parameter int PulsePeriod = 1100000,
	parameter int PulseLowLimit = 50000,
	parameter int PulseRangeStep = 250,
	parameter int HeartbeatCycles = 25000000
) (
	input  wire        OSC_FPGA,
	input  wire        rstN_i,
	// Host SPI
	input  wire        spiSck_i,
	input  wire        spiMosi_i,
	input  wire        spiSsN_i,
	// Wheel encoders
	input  wire        encLeftA_i,
	input  wire        encLeftB_i,
	input  wire        encRightA_i,
	input  wire        encRightB_i,
	// RC receiver channels
	input  wire        rcLeft_i,
	input  wire        rcRight_i,
	input  wire [3:0]  dipSw_i,
	output logic       motorLeft_o,
	output logic       motorRight_o,
	output logic [7:0] leds_o
);

	import botPkg::*;

	cmdFrame_t cmd;
	logic cmdValid;
	logic [COUNT_W-1:0] leftCount;
	logic [COUNT_W-1:0] rightCount;
	encCounts_t encCounts;
	logic [COUNT_W-1:0] rightPulseWidth;

	assign encCounts = '{left: leftCount, right: rightCount};

	// ----------------------------------------
	// Host command and encoders
	// ----------------------------------------

	spiCommandSlave spiCommandSlave_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN_i),
		.spiSck_i(spiSck_i),
		.spiMosi_i(spiMosi_i),
		.spiSsN_i(spiSsN_i),
		.cmd_o(cmd),
		.cmdValid_o(cmdValid)
	);

	quadratureCounter encLeft_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN_i),
		.encA_i(encLeftA_i),
		.encB_i(encLeftB_i),
		.count_o(leftCount)
	);

	quadratureCounter encRight_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN_i),
		.encA_i(encRightA_i),
		.encB_i(encRightB_i),
		.count_o(rightCount)
	);

	// ----------------------------------------
	// Motor outputs and debug LEDs
	// ----------------------------------------

	motorDrive #(
		.PulsePeriod(PulsePeriod),
		.PulseLowLimit(PulseLowLimit),
		.PulseRangeStep(PulseRangeStep)
	) motorDrive_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN_i),
		.cmd_i(cmd),
		.cmdValid_i(cmdValid),
		.rcLeft_i(rcLeft_i),
		.rcRight_i(rcRight_i),
		.motorLeft_o(motorLeft_o),
		.motorRight_o(motorRight_o),
		.rightPulseWidth_o(rightPulseWidth)
	);

	ledDebugDisplay #(.HeartbeatCycles(HeartbeatCycles)) ledDebugDisplay_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN_i),
		.dipSw_i(dipSw_i),
		.encCounts_i(encCounts),
		.cmd_i(cmd),
		.rightPulseWidth_i(rightPulseWidth),
		.leds_o(leds_o)
	);

endmodule

`default_nettype wire

// File: tb/botTb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module botTb_checker #(
	parameter int PulseLowLimit = 50000,
	parameter int PulseRangeStep = 250
) (
	input wire                        OSC_FPGA,
	input wire                        rstN_i,
	input wire                        cmdValid_i,
	input wire [botPkg::COUNT_W-1:0]  leftWidth_i,
	input wire [botPkg::COUNT_W-1:0]  rightWidth_i
);

	import botPkg::*;

	// Legal on-time, 0 to 200 percent
	localparam logic [COUNT_W-1:0] WidthMin = COUNT_W'(PulseLowLimit);
	localparam logic [COUNT_W-1:0] WidthMax = COUNT_W'(PulseLowLimit + 200 * PulseRangeStep);

	// Count of failed checks
	int failCount = 0;

	// Command strobe is a single cycle
	strobeSingle: assert property (@(posedge OSC_FPGA) disable iff (!rstN_i)
		cmdValid_i |=> !cmdValid_i)
	else
	begin
		$error("cmdValid high for two cycles");
		failCount++;
	end

	leftWidthRange: assert property (@(posedge OSC_FPGA) disable iff (!rstN_i)
		leftWidth_i >= WidthMin && leftWidth_i <= WidthMax)
	else
	begin
		$error("left pulse width out of range: %0d", leftWidth_i);
		failCount++;
	end

	rightWidthRange: assert property (@(posedge OSC_FPGA) disable iff (!rstN_i)
		rightWidth_i >= WidthMin && rightWidth_i <= WidthMax)
	else
	begin
		$error("right pulse width out of range: %0d", rightWidth_i);
		failCount++;
	end

endmodule

bind motorDrive botTb_checker #(
	.PulseLowLimit(PulseLowLimit),
	.PulseRangeStep(PulseRangeStep)
) motorChecker_i (
	.OSC_FPGA(OSC_FPGA),
	.rstN_i(rstN_i),
	.cmdValid_i(cmdValid_i),
	.leftWidth_i(leftWidth),
	.rightWidth_i(rightWidth)
);

`default_nettype wire

// File: tb/botTb.sv
`timescale 1ns/100ps
`default_nettype none

module botTb;

	import botPkg::*;

	// Small values so a pulse period is short
	localparam int PulsePeriod = 400;
	localparam int PulseLowLimit = 20;
	localparam int PulseRangeStep = 1;
	localparam int HeartbeatCycles = 16;

	// One row of stimulus and expected results
	typedef struct packed {
		logic [31:0] frame;
		// 0 means no frame
		logic [5:0] bitCount;
		logic [7:0] encSteps;
		logic encRight;
		logic encReverse;
		// {left, right}
		logic [1:0] rcLevels;
		logic [3:0] dipMode;
		logic [7:0] expLeds;
		logic passthrough;
		logic checkPulse;
		logic [8:0] expLeftHigh;
		logic [8:0] expRightHigh;
	} stimRow_t;

	logic OSC_FPGA;
	logic rstN;
	logic spiSck;
	logic spiMosi;
	logic spiSsN;
	logic encLeftA;
	logic encLeftB;
	logic encRightA;
	logic encRightB;
	logic rcLeft;
	logic rcRight;
	logic [3:0] dipSw;
	logic motorLeft;
	logic motorRight;
	logic [7:0] leds;

	integer seed;
	stimRow_t rows[$];

	// Reference model state
	cmdFrame_t modelCmd;
	logic [31:0] modelLeftCount;
	logic [31:0] modelRightCount;
	// Quadrature phase, 0 to 3
	logic [1:0] leftPhase;
	logic [1:0] rightPhase;

	botTop #(
		.PulsePeriod(PulsePeriod),
		.PulseLowLimit(PulseLowLimit),
		.PulseRangeStep(PulseRangeStep),
		.HeartbeatCycles(HeartbeatCycles)
	) botTop_i (
		.OSC_FPGA(OSC_FPGA),
		.rstN_i(rstN),
		.spiSck_i(spiSck),
		.spiMosi_i(spiMosi),
		.spiSsN_i(spiSsN),
		.encLeftA_i(encLeftA),
		.encLeftB_i(encLeftB),
		.encRightA_i(encRightA),
		.encRightB_i(encRightB),
		.rcLeft_i(rcLeft),
		.rcRight_i(rcRight),
		.dipSw_i(dipSw),
		.motorLeft_o(motorLeft),
		.motorRight_o(motorRight),
		.leds_o(leds)
	);

	// 100 ns clock
	always #50 OSC_FPGA = ~OSC_FPGA;

	task automatic failRun(input string msg);
		$display("Errors found");
		$fatal(1, "%s", msg);
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	// {A,B} for each phase, forward order
	function automatic logic [1:0] quadState(input logic [1:0] phase);
		case (phase)
			2'd0: return 2'b00;
			2'd1: return 2'b10;
			2'd2: return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	function automatic logic [7:0] ledsFor(input logic [3:0] mode);
		logic [31:0] cmdBits;
		logic [31:0] width;
		cmdBits = modelCmd;
		width = PulseLowLimit + modelCmd.rightPercent * PulseRangeStep;
		if (mode == 4'd0)
			return modelLeftCount[7:0];
		else if (mode == 4'd1)
			return modelRightCount[7:0];
		else if (mode >= 4'd8 && mode <= 4'd11)
			return cmdBits[8 * mode[1:0] +: 8];
		else if (mode >= 4'd12)
			return width[8 * mode[1:0] +: 8];
		return 8'h00;
	endfunction

	// Random percents stay within 0 to 200
	task automatic makeFrame(input logic flag, output logic [31:0] frame);
		logic [31:0] r;
		logic [7:0] rightPct;
		logic [7:0] leftPct;
		r = $random(seed);
		rightPct = r[7:0] % 201;
		leftPct = r[15:8] % 201;
		// First wire byte is the flags byte
		frame = {r[23:17], flag, rightPct, leftPct, r[31:24]};
	endtask

	task automatic addRow(
		input logic [31:0] frame,
		input logic [5:0]  bits,
		input logic [7:0]  steps,
		input logic        encRight,
		input logic        encReverse,
		input logic [1:0]  rc,
		input logic [3:0]  mode,
		input logic        checkPulse
	);
		stimRow_t row;
		// Only a full frame takes effect
		if (bits == 6'd32)
		begin
			modelCmd.flags = frame[31:24];
			modelCmd.rightPercent = frame[23:16];
			modelCmd.leftPercent = frame[15:8];
			modelCmd.spare = frame[7:0];
		end
		if (encRight)
			modelRightCount = encReverse ? modelRightCount - steps : modelRightCount + steps;
		else
			modelLeftCount = encReverse ? modelLeftCount - steps : modelLeftCount + steps;
		row.frame = frame;
		row.bitCount = bits;
		row.encSteps = steps;
		row.encRight = encRight;
		row.encReverse = encReverse;
		row.rcLevels = rc;
		row.dipMode = mode;
		row.expLeds = ledsFor(mode);
		row.passthrough = !modelCmd.flags.motorSourceSelect;
		row.checkPulse = checkPulse;
		row.expLeftHigh = PulseLowLimit + modelCmd.leftPercent * PulseRangeStep;
		row.expRightHigh = PulseLowLimit + modelCmd.rightPercent * PulseRangeStep;
		rows.push_back(row);
	endtask

	task automatic buildTable();
		logic [31:0] frameA;
		logic [31:0] frameB;
		logic [31:0] frameC;
		logic [7:0] nSteps;
		logic [7:0] mSteps;
		// State after reset, motors at rest and RC passthrough
		modelCmd = '0;
		modelCmd.leftPercent = 8'd100;
		modelCmd.rightPercent = 8'd100;
		modelLeftCount = 32'h8000_0000;
		modelRightCount = 32'h8000_0000;
		makeFrame(1'b1, frameA);
		makeFrame(1'b0, frameB);
		makeFrame(1'b0, frameC);
		nSteps = 8'(($random(seed) & 63) + 1);
		mSteps = 8'(($random(seed) & 63) + 1);
		addRow('0, 6'd0, 8'd0, 1'b0, 1'b0, 2'b01, 4'd0, 1'b0);
		addRow(frameA, 6'd32, 8'd0, 1'b0, 1'b0, 2'b10, 4'd8, 1'b1);
		addRow('0, 6'd0, 8'd0, 1'b0, 1'b0, 2'b10, 4'd9, 1'b0);
		addRow('0, 6'd0, 8'd0, 1'b0, 1'b0, 2'b10, 4'd10, 1'b0);
		addRow('0, 6'd0, 8'd0, 1'b0, 1'b0, 2'b10, 4'd11, 1'b0);
		addRow('0, 6'd0, 8'd0, 1'b0, 1'b0, 2'b10, 4'd12, 1'b0);
		// Short frame, nothing changes
		addRow(frameB, 6'd24, 8'd0, 1'b0, 1'b0, 2'b10, 4'd8, 1'b0);
		addRow('0, 6'd0, 8'd0, 1'b0, 1'b0, 2'b10, 4'd12, 1'b1);
		addRow('0, 6'd0, nSteps, 1'b0, 1'b0, 2'b00, 4'd0, 1'b0);
		addRow('0, 6'd0, mSteps, 1'b1, 1'b1, 2'b00, 4'd1, 1'b0);
		// Back to passthrough
		addRow(frameC, 6'd32, 8'd0, 1'b0, 1'b0, 2'b10, 4'd10, 1'b0);
		addRow('0, 6'd0, 8'd0, 1'b0, 1'b0, 2'b01, 4'd11, 1'b0);
	endtask

	// ----------------------------------------
	// Bus and pin drivers
	// ----------------------------------------

	// Mode 0, SCK at a tenth of the clock
	task automatic sendFrame(input logic [31:0] frame, input logic [5:0] bits);
		int i;
		int guard;
		logic seen;
		@(posedge OSC_FPGA);
		spiSsN <= 1'b0;
		repeat (5) @(posedge OSC_FPGA);
		for (i = 0; i < bits; i++)
		begin
			spiMosi <= frame[31 - i];
			repeat (5) @(posedge OSC_FPGA);
			spiSck <= 1'b1;
			repeat (5) @(posedge OSC_FPGA);
			spiSck <= 1'b0;
		end
		repeat (5) @(posedge OSC_FPGA);
		spiSsN <= 1'b1;
		seen = 1'b0;
		for (guard = 0; guard < 10 && !seen; guard++)
		begin
			@(negedge OSC_FPGA);
			if (botTop_i.cmdValid)
				seen = 1'b1;
		end
		// Strobe due within 4 cycles of the chip select rise
		if (bits == 6'd32)
			assert (seen && guard <= 4)
			else
				failRun("no command strobe within 4 cycles of a 32-bit frame");
		else
			assert (!seen) else failRun($sformatf("command strobe after a %0d-bit frame", bits));
	endtask

	task automatic stepEncoder(input logic right, input logic reverse, input logic [7:0] steps);
		int i;
		logic [1:0] ab;
		for (i = 0; i < steps; i++)
		begin
			@(posedge OSC_FPGA);
			if (right)
			begin
				rightPhase = reverse ? rightPhase - 2'd1 : rightPhase + 2'd1;
				ab = quadState(rightPhase);
				encRightA <= ab[1];
				encRightB <= ab[0];
			end
			else
			begin
				leftPhase = reverse ? leftPhase - 2'd1 : leftPhase + 2'd1;
				ab = quadState(leftPhase);
				encLeftA <= ab[1];
				encLeftB <= ab[0];
			end
			// 5 cycles per step
			repeat (4) @(posedge OSC_FPGA);
		end
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// LED register follows a new mode after one cycle
	task automatic checkLeds(input logic [7:0] expected);
		@(posedge OSC_FPGA);
		@(negedge OSC_FPGA);
		assert (leds === expected)
		else
			failRun($sformatf("MISMATCH at %0t: leds_o = %h, expected %h",
				$time, leds, expected));
	endtask

	function automatic logic motorOut(input logic sel);
		return sel ? motorRight : motorLeft;
	endfunction

	// High time of the next full pulse
	task automatic measureHigh(input logic sel, output int width);
		int guard;
		guard = 0;
		width = 0;
		while (motorOut(sel) && guard < 2 * PulsePeriod)
		begin
			@(negedge OSC_FPGA);
			guard++;
		end
		while (!motorOut(sel) && guard < 2 * PulsePeriod)
		begin
			@(negedge OSC_FPGA);
			guard++;
		end
		while (motorOut(sel) && guard < 2 * PulsePeriod)
		begin
			width++;
			@(negedge OSC_FPGA);
			guard++;
		end
		assert (guard < 2 * PulsePeriod) else failRun("timeout while measuring a motor pulse");
	endtask

	task automatic applyRow(input stimRow_t row);
		int leftHigh;
		int rightHigh;
		@(posedge OSC_FPGA);
		rcLeft <= row.rcLevels[1];
		rcRight <= row.rcLevels[0];
		if (row.bitCount != 6'd0)
			sendFrame(row.frame, row.bitCount);
		if (row.encSteps != 8'd0)
			stepEncoder(row.encRight, row.encReverse, row.encSteps);
		@(posedge OSC_FPGA);
		dipSw <= row.dipMode;
		checkLeds(row.expLeds);
		if (row.passthrough)
		begin
			assert (motorLeft === row.rcLevels[1])
			else
				failRun($sformatf("MISMATCH at %0t: motorLeft_o = %b, expected %b",
					$time, motorLeft, row.rcLevels[1]));
			assert (motorRight === row.rcLevels[0])
			else
				failRun($sformatf("MISMATCH at %0t: motorRight_o = %b, expected %b",
					$time, motorRight, row.rcLevels[0]));
		end
		if (row.checkPulse)
		begin
			measureHigh(1'b0, leftHigh);
			assert (leftHigh == row.expLeftHigh)
			else
				failRun($sformatf("MISMATCH at %0t: motorLeft_o high time = %0d, expected %0d",
					$time, leftHigh, row.expLeftHigh));
			measureHigh(1'b1, rightHigh);
			assert (rightHigh == row.expRightHigh)
			else
				failRun($sformatf("MISMATCH at %0t: motorRight_o high time = %0d, expected %0d",
					$time, rightHigh, row.expRightHigh));
		end
	endtask

	// Two inversions of the last shown value, each within 20 cycles
	task automatic checkHeartbeat(input logic [7:0] start);
		logic [7:0] expected;
		int flip;
		int guard;
		@(posedge OSC_FPGA);
		dipSw <= 4'd7;
		@(negedge OSC_FPGA);
		expected = start;
		for (flip = 0; flip < 2; flip++)
		begin
			expected = ~expected;
			for (guard = 0; guard < 20 && leds !== expected; guard++)
				@(negedge OSC_FPGA);
			assert (leds === expected)
			else
				failRun($sformatf("MISMATCH at %0t: leds_o = %h, expected %h",
					$time, leds, expected));
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial
	begin
		OSC_FPGA = 1'b0;
		rstN = 1'b0;
		spiSck = 1'b0;
		spiMosi = 1'b0;
		spiSsN = 1'b1;
		encLeftA = 1'b0;
		encLeftB = 1'b0;
		encRightA = 1'b0;
		encRightB = 1'b0;
		rcLeft = 1'b0;
		rcRight = 1'b0;
		dipSw = 4'd0;
		leftPhase = 2'd0;
		rightPhase = 2'd0;
		seed = 32'hb82f_b7ec;
		buildTable();
		repeat (8) @(posedge OSC_FPGA);
		rstN <= 1'b1;
		@(negedge OSC_FPGA);
		assert (leds === 8'h00)
		else
			failRun($sformatf("MISMATCH at %0t: leds_o = %h, expected 00", $time, leds));
		foreach (rows[i])
			applyRow(rows[i]);
		checkHeartbeat(rows[rows.size() - 1].expLeds);
		if (botTop_i.motorDrive_i.motorChecker_i.failCount == 0)
		begin
			$display("No errors");
			$finish;
		end
		else
			failRun("concurrent assertions on the motor drive failed");
	end

endmodule

`default_nettype wire

// File: sources.f
hdl/botPkg.sv
hdl/spiCommandSlave.sv
hdl/quadratureCounter.sv
hdl/rcPulseGenerator.sv
hdl/motorDrive.sv
hdl/ledDebugDisplay.sv
hdl/botTop.sv
tb/botTb_checker.sv
tb/botTb.sv
